// ==== src/dma_writer_pkg.sv ====
`default_nettype none

package dma_writer_pkg;

    // stream and AXI data path
    localparam int DATA_W = 32;
    typedef logic [DATA_W-1:0] word_t;

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_LEN_W = 8;

    // burst length as a plain word count, 1 to 256
    typedef logic [AXI_LEN_W:0] len_t;

    localparam int WORD_BYTES_LOG2 = 2;

    // ------------------------------
    // fixed AW fields
    localparam logic [2:0] AWSIZE_WORD = 3'b010;
    localparam logic [1:0] AWBURST_INCR = 2'b01;
    localparam logic [3:0] AWCACHE_DEFAULT = 4'b0001;

endpackage

`default_nettype wire

// ==== src/burst_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface burst_if import dma_writer_pkg::*; #(
    parameter int SIZE_W = 24
) ();

    logic [SIZE_W-1:0] addr;
    len_t              len;
    logic              valid;
    logic              ready;

    modport source (output addr, output len, output valid, input ready);
    modport sink (input addr, input len, input valid, output ready);

endinterface

`default_nettype wire

// ==== src/sync_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH_LOG2 = 4
) (
    input  logic     i_aclk,
    input  logic     i_rst_n,
    input  payload_t i_data,
    input  logic     i_valid,
    output logic     o_ready,
    output logic     o_push,
    output payload_t o_data,
    output logic     o_valid,
    input  logic     i_ready
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    payload_t              mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic                  pop;

    assign o_ready = (count != DEPTH[DEPTH_LOG2:0]);
    assign o_valid = (count != '0);
    assign o_push = i_valid && o_ready;
    assign pop = o_valid && i_ready;

    // head word is read straight from the array
    assign o_data = mem[rd_ptr];

    always_ff @(posedge i_aclk) begin
        if (o_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (o_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (o_push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
        end
    end

endmodule

`default_nettype wire

// ==== src/capacity_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module capacity_ctrl import dma_writer_pkg::*; #(
    parameter int SIZE_W = 24
) (
    input  logic              i_aclk,
    input  logic              i_rst_n,
    input  logic              i_enable,
    input  logic [SIZE_W-1:0] i_param_size,
    input  logic              i_push,
    input  len_t              i_permit_size,
    input  logic              i_permit_valid,
    input  len_t              i_complete_size,
    input  logic              i_complete_valid,
    output logic              o_busy,
    output logic [SIZE_W-1:0] o_issue_size,
    output logic              o_issue_valid
);

    logic [SIZE_W-1:0] pending;
    logic [SIZE_W-1:0] budget;
    logic [SIZE_W-1:0] outstanding;
    logic [SIZE_W-1:0] grant;
    logic [SIZE_W-1:0] permit_add;
    logic [SIZE_W-1:0] complete_sub;

    // release as much as both the FIFO and the ring allow
    always_comb begin
        grant = '0;
        if (o_busy && i_enable) begin
            grant = (pending < budget) ? pending : budget;
        end
    end

    assign permit_add = i_permit_valid ? SIZE_W'(i_permit_size) : '0;
    assign complete_sub = i_complete_valid ? SIZE_W'(i_complete_size) : '0;

    always_ff @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_busy <= 1'b0;
            pending <= '0;
            budget <= '0;
            outstanding <= '0;
            o_issue_size <= '0;
            o_issue_valid <= 1'b0;
        end else begin
            if (!o_busy) begin
                o_busy <= i_enable;
            end else if (!i_enable && outstanding == '0) begin
                o_busy <= 1'b0;
            end

            // words pushed before enable still count
            pending <= pending + SIZE_W'(i_push) - grant;

            if (!o_busy) begin
                budget <= i_param_size;
            end else begin
                budget <= budget - grant + permit_add;
            end

            outstanding <= outstanding + grant - complete_sub;
            o_issue_size <= grant;
            o_issue_valid <= (grant != '0);
        end
    end

endmodule

`default_nettype wire

// ==== src/burst_timeout.sv ====
`timescale 1ns/10ps
`default_nettype none

module burst_timeout import dma_writer_pkg::*; #(
    parameter int SIZE_W = 24,
    parameter int TIMER_W = 8
) (
    input  logic               i_aclk,
    input  logic               i_rst_n,
    input  len_t               i_max_len,
    input  logic [TIMER_W-1:0] i_timeout,
    input  logic [SIZE_W-1:0]  i_issue_size,
    input  logic               i_issue_valid,
    output len_t               o_len,
    output logic               o_valid,
    input  logic               i_ready
);

    logic [SIZE_W-1:0]  queued;
    logic [SIZE_W-1:0]  max_len;
    logic [SIZE_W-1:0]  add;
    logic [SIZE_W-1:0]  take;
    logic [TIMER_W-1:0] timer;
    logic               load;

    assign max_len = SIZE_W'(i_max_len);
    assign add = i_issue_valid ? i_issue_size : '0;
    assign load = !o_valid || i_ready;

    // full bursts first, remainder only once idle long enough
    always_comb begin
        take = '0;
        if (load) begin
            if (queued >= max_len) begin
                take = max_len;
            end else if (queued != '0 && timer >= i_timeout) begin
                take = queued;
            end
        end
    end

    always_ff @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            queued <= '0;
            timer <= '0;
            o_valid <= 1'b0;
        end else begin
            queued <= queued - take + add;

            if (i_issue_valid || take != '0) begin
                timer <= '0;
            end else if (queued != '0 && timer != i_timeout) begin
                timer <= timer + 1'b1;
            end

            if (load) begin
                o_valid <= (take != '0);
            end
        end
    end

    always_ff @(posedge i_aclk) begin
        if (load) begin
            o_len <= len_t'(take);
        end
    end

endmodule

`default_nettype wire

// ==== src/ring_addr_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module ring_addr_gen import dma_writer_pkg::*; #(
    parameter int SIZE_W = 24
) (
    input  logic              i_aclk,
    input  logic              i_rst_n,
    input  logic              i_busy,
    input  logic [SIZE_W-1:0] i_param_size,
    input  len_t              i_len,
    input  logic              i_valid,
    output logic              o_ready,
    burst_if.source           o_cmd
);

    logic [SIZE_W-1:0] addr;
    logic [SIZE_W-1:0] room;
    logic [SIZE_W-1:0] addr_end;
    len_t              sent;
    len_t              cur;
    logic              split;
    logic              emit;

    // part of the input burst not yet emitted
    assign cur = i_len - sent;
    assign room = i_param_size - addr;
    assign split = (SIZE_W'(cur) > room);
    assign addr_end = addr + SIZE_W'(cur);

    assign emit = i_valid && (!o_cmd.valid || o_cmd.ready);
    assign o_ready = emit && !split;

    always_ff @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr <= '0;
            sent <= '0;
            o_cmd.valid <= 1'b0;
        end else begin
            o_cmd.valid <= emit || (o_cmd.valid && !o_cmd.ready);

            if (!i_busy) begin
                addr <= '0;
                sent <= '0;
            end else if (emit) begin
                if (split) begin
                    // fill up to the ring end, rest starts at 0
                    addr <= '0;
                    sent <= sent + len_t'(room);
                end else begin
                    addr <= (addr_end == i_param_size) ? '0 : addr_end;
                    sent <= '0;
                end
            end
        end
    end

    always_ff @(posedge i_aclk) begin
        if (emit) begin
            o_cmd.addr <= addr;
            o_cmd.len <= split ? len_t'(room) : cur;
        end
    end

endmodule

`default_nettype wire

// ==== src/burst_dispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

module burst_dispatch import dma_writer_pkg::*; #(
    parameter int SIZE_W = 24
) (
    burst_if.sink                  i_cmd,
    input  logic                   i_aclk,
    input  logic                   i_rst_n,
    input  logic [AXI_ADDR_W-1:0]  i_param_addr,
    input  word_t                  i_wdata,
    input  logic                   i_wvalid,
    output logic                   o_wready,
    output logic [AXI_ADDR_W-1:0]  o_awaddr,
    output logic [AXI_LEN_W-1:0]   o_awlen,
    output logic                   o_awvalid,
    input  logic                   i_awready,
    output word_t                  o_wdata,
    output logic                   o_wlast,
    output logic                   o_wvalid,
    input  logic                   i_wready,
    input  logic                   i_bvalid,
    output logic                   o_bready,
    output len_t                   o_complete_size,
    output logic                   o_complete_valid
);

    localparam int LEN_FIFO_DEPTH_LOG2 = 5;

    logic aw_done;
    logic wl_done;
    logic bq_done;
    logic wl_push_ready;
    logic bq_push_ready;
    logic cmd_fire;
    len_t wl_len;
    logic wl_valid;
    logic wl_pop;
    len_t bq_len;
    logic bq_valid;
    len_t beat_cnt;
    logic w_fire;

    // ------------------------------
    // command fork

    assign o_awaddr = i_param_addr + (AXI_ADDR_W'(i_cmd.addr) << WORD_BYTES_LOG2);
    assign o_awlen = AXI_LEN_W'(i_cmd.len - 1'b1);
    assign o_awvalid = i_cmd.valid && !aw_done;

    assign i_cmd.ready = (aw_done || i_awready) && (wl_done || wl_push_ready)
                         && (bq_done || bq_push_ready);
    assign cmd_fire = i_cmd.valid && i_cmd.ready;

    always_ff @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            aw_done <= 1'b0;
            wl_done <= 1'b0;
            bq_done <= 1'b0;
        end else if (cmd_fire) begin
            aw_done <= 1'b0;
            wl_done <= 1'b0;
            bq_done <= 1'b0;
        end else begin
            if (o_awvalid && i_awready) begin
                aw_done <= 1'b1;
            end
            if (i_cmd.valid && wl_push_ready) begin
                wl_done <= 1'b1;
            end
            if (i_cmd.valid && bq_push_ready) begin
                bq_done <= 1'b1;
            end
        end
    end

    sync_fifo #(
        .payload_t  (len_t),
        .DEPTH_LOG2 (LEN_FIFO_DEPTH_LOG2)
    ) wlast_fifo_i (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .i_data  (i_cmd.len),
        .i_valid (i_cmd.valid && !wl_done),
        .o_ready (wl_push_ready),
        .o_push  (),
        .o_data  (wl_len),
        .o_valid (wl_valid),
        .i_ready (wl_pop)
    );

    sync_fifo #(
        .payload_t  (len_t),
        .DEPTH_LOG2 (LEN_FIFO_DEPTH_LOG2)
    ) resp_fifo_i (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .i_data  (i_cmd.len),
        .i_valid (i_cmd.valid && !bq_done),
        .o_ready (bq_push_ready),
        .o_push  (),
        .o_data  (bq_len),
        .o_valid (bq_valid),
        .i_ready (i_bvalid)
    );

    // ------------------------------
    // W beats, gated by a known burst length

    assign o_wdata = i_wdata;
    assign o_wvalid = i_wvalid && wl_valid;
    assign o_wready = i_wready && wl_valid;
    assign o_wlast = (beat_cnt == wl_len - 1'b1);
    assign w_fire = o_wvalid && i_wready;
    assign wl_pop = w_fire && o_wlast;

    always_ff @(posedge i_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            beat_cnt <= '0;
        end else if (w_fire) begin
            beat_cnt <= o_wlast ? '0 : beat_cnt + 1'b1;
        end
    end

    // one completion per write response
    assign o_bready = 1'b1;
    assign o_complete_size = bq_len;
    assign o_complete_valid = i_bvalid && bq_valid;

endmodule

`default_nettype wire

// ==== src/dma_fifo_writer.sv ====
`timescale 1ns/10ps
`default_nettype none

module dma_fifo_writer import dma_writer_pkg::*; #(
    parameter int SIZE_W = 24,
    parameter int TIMER_W = 8,
    parameter int FIFO_DEPTH_LOG2 = 9
) (
    input  logic                  i_aclk,
    input  logic                  i_rst_n,
    input  logic                  i_enable,
    output logic                  o_busy,

    input  logic [AXI_ADDR_W-1:0] i_param_addr,
    input  logic [SIZE_W-1:0]     i_param_size,
    input  len_t                  i_param_max_len,
    input  logic [TIMER_W-1:0]    i_param_timeout,

    input  word_t                 i_s_data,
    input  logic                  i_s_valid,
    output logic                  o_s_ready,

    input  len_t                  i_permit_size,
    input  logic                  i_permit_valid,
    output len_t                  o_complete_size,
    output logic                  o_complete_valid,

    output logic [AXI_ADDR_W-1:0] o_m_axi_awaddr,
    output logic [AXI_LEN_W-1:0]  o_m_axi_awlen,
    output logic [2:0]            o_m_axi_awsize,
    output logic [1:0]            o_m_axi_awburst,
    output logic [3:0]            o_m_axi_awcache,
    output logic                  o_m_axi_awvalid,
    input  logic                  i_m_axi_awready,
    output word_t                 o_m_axi_wdata,
    output logic [DATA_W/8-1:0]   o_m_axi_wstrb,
    output logic                  o_m_axi_wlast,
    output logic                  o_m_axi_wvalid,
    input  logic                  i_m_axi_wready,
    input  logic [1:0]            i_m_axi_bresp,
    input  logic                  i_m_axi_bvalid,
    output logic                  o_m_axi_bready
);

    word_t             fifo_data;
    logic              fifo_valid;
    logic              fifo_ready;
    logic              fifo_push;
    logic [SIZE_W-1:0] issue_size;
    logic              issue_valid;
    len_t              tmo_len;
    logic              tmo_valid;
    logic              tmo_ready;

    burst_if #(.SIZE_W(SIZE_W)) cmd_if ();

    // ------------------------------
    // stream input and budget

    sync_fifo #(
        .payload_t  (word_t),
        .DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) data_fifo_i (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .i_data  (i_s_data),
        .i_valid (i_s_valid),
        .o_ready (o_s_ready),
        .o_push  (fifo_push),
        .o_data  (fifo_data),
        .o_valid (fifo_valid),
        .i_ready (fifo_ready)
    );

    capacity_ctrl #(
        .SIZE_W (SIZE_W)
    ) capacity_ctrl_i (
        .i_aclk           (i_aclk),
        .i_rst_n          (i_rst_n),
        .i_enable         (i_enable),
        .i_param_size     (i_param_size),
        .i_push           (fifo_push),
        .i_permit_size    (i_permit_size),
        .i_permit_valid   (i_permit_valid),
        .i_complete_size  (o_complete_size),
        .i_complete_valid (o_complete_valid),
        .o_busy           (o_busy),
        .o_issue_size     (issue_size),
        .o_issue_valid    (issue_valid)
    );

    // ------------------------------
    // burst forming

    burst_timeout #(
        .SIZE_W  (SIZE_W),
        .TIMER_W (TIMER_W)
    ) burst_timeout_i (
        .i_aclk        (i_aclk),
        .i_rst_n       (i_rst_n),
        .i_max_len     (i_param_max_len),
        .i_timeout     (i_param_timeout),
        .i_issue_size  (issue_size),
        .i_issue_valid (issue_valid),
        .o_len         (tmo_len),
        .o_valid       (tmo_valid),
        .i_ready       (tmo_ready)
    );

    ring_addr_gen #(
        .SIZE_W (SIZE_W)
    ) ring_addr_gen_i (
        .i_aclk       (i_aclk),
        .i_rst_n      (i_rst_n),
        .i_busy       (o_busy),
        .i_param_size (i_param_size),
        .i_len        (tmo_len),
        .i_valid      (tmo_valid),
        .o_ready      (tmo_ready),
        .o_cmd        (cmd_if.source)
    );

    // ------------------------------
    // AXI write channels

    burst_dispatch #(
        .SIZE_W (SIZE_W)
    ) burst_dispatch_i (
        .i_cmd            (cmd_if.sink),
        .i_aclk           (i_aclk),
        .i_rst_n          (i_rst_n),
        .i_param_addr     (i_param_addr),
        .i_wdata          (fifo_data),
        .i_wvalid         (fifo_valid),
        .o_wready         (fifo_ready),
        .o_awaddr         (o_m_axi_awaddr),
        .o_awlen          (o_m_axi_awlen),
        .o_awvalid        (o_m_axi_awvalid),
        .i_awready        (i_m_axi_awready),
        .o_wdata          (o_m_axi_wdata),
        .o_wlast          (o_m_axi_wlast),
        .o_wvalid         (o_m_axi_wvalid),
        .i_wready         (i_m_axi_wready),
        .i_bvalid         (i_m_axi_bvalid),
        .o_bready         (o_m_axi_bready),
        .o_complete_size  (o_complete_size),
        .o_complete_valid (o_complete_valid)
    );

    // error responses are not reported, every B completes its burst
    assign o_m_axi_awsize = AWSIZE_WORD;
    assign o_m_axi_awburst = AWBURST_INCR;
    assign o_m_axi_awcache = AWCACHE_DEFAULT;
    assign o_m_axi_wstrb = '1;

endmodule

`default_nettype wire

// ==== test/tb_axi_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem_model import dma_writer_pkg::*; (
    input  logic                  i_aclk,
    input  logic                  i_rst_n,
    input  logic [AXI_ADDR_W-1:0] i_awaddr,
    input  logic [AXI_LEN_W-1:0]  i_awlen,
    input  logic                  i_awvalid,
    output logic                  o_awready,
    input  word_t                 i_wdata,
    input  logic                  i_wlast,
    input  logic                  i_wvalid,
    output logic                  o_wready,
    output logic [1:0]            o_bresp,
    output logic                  o_bvalid,
    input  logic                  i_bready
);

    // captured traffic, read by the testbench
    logic [AXI_ADDR_W-1:0] aw_addr_q [$];
    logic [AXI_LEN_W-1:0]  aw_len_q [$];
    word_t                 w_data_q [$];
    logic                  w_last_q [$];
    int                    b_count;

    int     b_due_q [$];
    int     cycle;
    integer seed;

    initial begin
        seed = 32'ha6ae_d76b;
        cycle = 0;
        b_count = 0;
        o_awready = 1'b0;
        o_wready = 1'b0;
        o_bresp = 2'b00;
        o_bvalid = 1'b0;
        forever begin
            @(posedge i_aclk);
            cycle++;
            if (i_rst_n) begin
                if (i_awvalid && o_awready) begin
                    aw_addr_q.push_back(i_awaddr);
                    aw_len_q.push_back(i_awlen);
                end
                if (i_wvalid && o_wready) begin
                    w_data_q.push_back(i_wdata);
                    w_last_q.push_back(i_wlast);
                    // response one to four cycles after the last beat
                    if (i_wlast) begin
                        b_due_q.push_back(cycle + 1 + ($random(seed) & 3));
                    end
                end
                if (o_bvalid && i_bready) begin
                    b_due_q.delete(0);
                    b_count++;
                end
            end
            #1;
            if (i_rst_n) begin
                o_awready = (($random(seed) & 3) != 0);
                o_wready = (($random(seed) & 3) != 0);
                o_bvalid = (b_due_q.size() > 0) && (cycle >= b_due_q[0]);
            end else begin
                o_awready = 1'b0;
                o_wready = 1'b0;
                o_bvalid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_dma_fifo_writer.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_dma_fifo_writer import dma_writer_pkg::*; ();

    localparam int SIZE_W = 24;
    localparam int TIMER_W = 8;
    localparam int FIFO_DEPTH_LOG2 = 5;
    localparam int FIFO_DEPTH = 1 << FIFO_DEPTH_LOG2;
    localparam int N_CASES = 4;
    localparam int MAX_BURSTS = 8;
    localparam int WAIT_LIMIT = 4000;
    localparam int HOLD_CYCLES = 20;

    logic                  aclk;
    logic                  rst_n;
    logic                  enable;
    logic                  busy;
    logic [AXI_ADDR_W-1:0] param_addr;
    logic [SIZE_W-1:0]     param_size;
    len_t                  param_max_len;
    logic [TIMER_W-1:0]    param_timeout;
    word_t                 s_data;
    logic                  s_valid;
    logic                  s_ready;
    len_t                  permit_size;
    logic                  permit_valid;
    len_t                  complete_size;
    logic                  complete_valid;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic [AXI_LEN_W-1:0]  awlen;
    logic [2:0]            awsize;
    logic [1:0]            awburst;
    logic [3:0]            awcache;
    logic                  awvalid;
    logic                  awready;
    word_t                 wdata;
    logic [DATA_W/8-1:0]   wstrb;
    logic                  wlast;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;

    // ------------------------------
    // one row per case for grouping, timeout flush, ring wrap and capacity
    logic [31:0] t_base [N_CASES] = '{32'h0000_1000, 32'h0000_2000, 32'h0000_8000, 32'h0000_c000};
    int t_size [N_CASES] = '{64, 64, 16, 16};
    int t_max_len [N_CASES] = '{8, 16, 6, 8};
    int t_timeout [N_CASES] = '{30, 10, 6, 8};
    int t_words [N_CASES] = '{20, 3, 36, 48};
    int t_permit [N_CASES] = '{0, 0, 20, 32};
    int t_bursts [N_CASES] = '{3, 1, 8, 6};
    int t_len [N_CASES][MAX_BURSTS] = '{
        '{8, 8, 4, 0, 0, 0, 0, 0},
        '{3, 0, 0, 0, 0, 0, 0, 0},
        '{6, 6, 4, 6, 6, 4, 2, 2},
        '{8, 8, 8, 8, 8, 8, 0, 0}
    };
    int t_addr [N_CASES][MAX_BURSTS] = '{
        '{0, 8, 16, 0, 0, 0, 0, 0},
        '{0, 0, 0, 0, 0, 0, 0, 0},
        '{0, 6, 12, 0, 6, 12, 0, 2},
        '{0, 8, 0, 8, 0, 8, 0, 0}
    };

    word_t exp_data [$];
    len_t  comp_q [$];
    word_t next_word;

    always #4 aclk = ~aclk;

    dma_fifo_writer #(
        .SIZE_W          (SIZE_W),
        .TIMER_W         (TIMER_W),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) dut_i (
        .i_aclk           (aclk),
        .i_rst_n          (rst_n),
        .i_enable         (enable),
        .o_busy           (busy),
        .i_param_addr     (param_addr),
        .i_param_size     (param_size),
        .i_param_max_len  (param_max_len),
        .i_param_timeout  (param_timeout),
        .i_s_data         (s_data),
        .i_s_valid        (s_valid),
        .o_s_ready        (s_ready),
        .i_permit_size    (permit_size),
        .i_permit_valid   (permit_valid),
        .o_complete_size  (complete_size),
        .o_complete_valid (complete_valid),
        .o_m_axi_awaddr   (awaddr),
        .o_m_axi_awlen    (awlen),
        .o_m_axi_awsize   (awsize),
        .o_m_axi_awburst  (awburst),
        .o_m_axi_awcache  (awcache),
        .o_m_axi_awvalid  (awvalid),
        .i_m_axi_awready  (awready),
        .o_m_axi_wdata    (wdata),
        .o_m_axi_wstrb    (wstrb),
        .o_m_axi_wlast    (wlast),
        .o_m_axi_wvalid   (wvalid),
        .i_m_axi_wready   (wready),
        .i_m_axi_bresp    (bresp),
        .i_m_axi_bvalid   (bvalid),
        .o_m_axi_bready   (bready)
    );

    tb_axi_mem_model mem_i (
        .i_aclk    (aclk),
        .i_rst_n   (rst_n),
        .i_awaddr  (awaddr),
        .i_awlen   (awlen),
        .i_awvalid (awvalid),
        .o_awready (awready),
        .i_wdata   (wdata),
        .i_wlast   (wlast),
        .i_wvalid  (wvalid),
        .o_wready  (wready),
        .o_bresp   (bresp),
        .o_bvalid  (bvalid),
        .i_bready  (bready)
    );

    // completion pulses in arrival order
    always @(posedge aclk) begin
        if (rst_n && complete_valid) begin
            comp_q.push_back(complete_size);
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else fail_run($sformatf(
            "Mismatch at %0t: %s expected 0x%0h got 0x%0h", $time, name, expected, actual));
    endtask

    task automatic send_words(input int n);
        int i;
        int waited;
        for (i = 0; i < n; i++) begin
            s_data = next_word;
            s_valid = 1'b1;
            waited = 0;
            while (!s_ready) begin
                @(posedge aclk);
                #1;
                waited++;
                if (waited > WAIT_LIMIT) fail_run("input stream stalled, o_s_ready stayed low");
            end
            @(posedge aclk);
            #1;
            exp_data.push_back(next_word);
            next_word = next_word + 1'b1;
        end
        s_valid = 1'b0;
    endtask

    task automatic issue_permit(input int n);
        permit_size = len_t'(n);
        permit_valid = 1'b1;
        @(posedge aclk);
        #1;
        permit_valid = 1'b0;
    endtask

    task automatic wait_beats(input int n);
        int waited;
        waited = 0;
        while (mem_i.w_data_q.size() < n) begin
            @(posedge aclk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) fail_run("timed out waiting for W beats to reach memory");
        end
    endtask

    task automatic wait_ready_low();
        int waited;
        waited = 0;
        while (s_ready) begin
            @(posedge aclk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) fail_run("o_s_ready never dropped with the FIFO full");
        end
    endtask

    task automatic wait_completions(input int n);
        int waited;
        waited = 0;
        while (comp_q.size() < n) begin
            @(posedge aclk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) fail_run("timed out waiting for burst completions");
        end
    endtask

    task automatic wait_busy_low();
        int waited;
        waited = 0;
        while (busy) begin
            @(posedge aclk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) fail_run("o_busy stayed high after enable dropped");
        end
    endtask

    task automatic run_case(input int c);
        int pre_words;
        int b_start;
        int beat;
        int b;
        int k;
        // budget starts at the ring size and permits add the rest
        pre_words = (t_words[c] < t_size[c]) ? t_words[c] : t_size[c];
        b_start = mem_i.b_count;
        mem_i.aw_addr_q.delete();
        mem_i.aw_len_q.delete();
        mem_i.w_data_q.delete();
        mem_i.w_last_q.delete();
        exp_data.delete();
        comp_q.delete();

        param_addr = t_base[c];
        param_size = SIZE_W'(t_size[c]);
        param_max_len = len_t'(t_max_len[c]);
        param_timeout = TIMER_W'(t_timeout[c]);
        enable = 1'b1;
        send_words(t_words[c]);

        wait_beats(pre_words);
        if (t_words[c] - pre_words >= FIFO_DEPTH) begin
            wait_ready_low();
        end
        repeat (HOLD_CYCLES) @(posedge aclk);
        #1;
        check_value("beats before permit", mem_i.w_data_q.size(), pre_words);

        if (t_permit[c] != 0) begin
            issue_permit(t_permit[c]);
        end
        wait_beats(t_words[c]);
        wait_completions(t_bursts[c]);

        check_value("aw burst count", mem_i.aw_addr_q.size(), t_bursts[c]);
        check_value("w beat count", mem_i.w_data_q.size(), t_words[c]);
        beat = 0;
        for (b = 0; b < t_bursts[c]; b++) begin
            check_value("m_axi_awaddr", mem_i.aw_addr_q[b], t_base[c] + 4 * t_addr[c][b]);
            check_value("m_axi_awlen", mem_i.aw_len_q[b], t_len[c][b] - 1);
            check_value("complete_size", comp_q[b], t_len[c][b]);
            for (k = 0; k < t_len[c][b]; k++) begin
                check_value("m_axi_wdata", mem_i.w_data_q[beat], exp_data[beat]);
                check_value("m_axi_wlast", mem_i.w_last_q[beat], k == t_len[c][b] - 1);
                beat++;
            end
        end

        check_value("o_busy before disable", busy, 1'b1);
        enable = 1'b0;
        wait_busy_low();
        check_value("completion count", comp_q.size(), t_bursts[c]);
        check_value("b response count", mem_i.b_count - b_start, t_bursts[c]);
    endtask

    initial begin
        int c;
        aclk = 1'b0;
        rst_n = 1'b0;
        enable = 1'b0;
        param_addr = '0;
        param_size = '0;
        param_max_len = '0;
        param_timeout = '0;
        s_data = '0;
        s_valid = 1'b0;
        permit_size = '0;
        permit_valid = 1'b0;
        next_word = 32'h0000_1000;

        repeat (16) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        @(posedge aclk);
        #1;

        // ------------------------------
        // idle state after reset
        check_value("o_busy", busy, 1'b0);
        check_value("o_s_ready", s_ready, 1'b1);
        check_value("o_complete_valid", complete_valid, 1'b0);
        check_value("m_axi_awvalid", awvalid, 1'b0);
        check_value("m_axi_wvalid", wvalid, 1'b0);
        check_value("m_axi_awsize", awsize, 3'b010);
        check_value("m_axi_awburst", awburst, 2'b01);
        check_value("m_axi_awcache", awcache, 4'b0001);
        check_value("m_axi_wstrb", wstrb, 4'hf);
        check_value("m_axi_bready", bready, 1'b1);

        for (c = 0; c < N_CASES; c++) begin
            run_case(c);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dma_fifo_writer.f ====
src/dma_writer_pkg.sv
src/burst_if.sv
src/sync_fifo.sv
src/capacity_ctrl.sv
src/burst_timeout.sv
src/ring_addr_gen.sv
src/burst_dispatch.sv
src/dma_fifo_writer.sv
test/tb_axi_mem_model.sv
test/tb_dma_fifo_writer.sv

// ==== Bender.yml ====
package:
  name: dma_fifo_writer

sources:
  - files:
      - src/dma_writer_pkg.sv
      - src/burst_if.sv
      - src/sync_fifo.sv
      - src/capacity_ctrl.sv
      - src/burst_timeout.sv
      - src/ring_addr_gen.sv
      - src/burst_dispatch.sv
      - src/dma_fifo_writer.sv
  - target: test
    files:
      - test/tb_axi_mem_model.sv
      - test/tb_dma_fifo_writer.sv
